/* include/opsum_params.svh */
`ifndef OPSUM_PARAMS_SVH
`define OPSUM_PARAMS_SVH

// PE array geometry
`define ROW_NUM      32
`define PE_COLS      3

// opsum storage
`define OPSUM_W      16
`define OPSUM_DEPTH  4

// global buffer port
`define GLB_W        32
`define GLB_AW       12

`endif

/* hdl/opsum_pkg.sv */
`include "opsum_params.svh"

package opsum_pkg;

  // --------------------------------------------------
  // layer configuration
  // --------------------------------------------------
  typedef enum logic [0:0] {
    layer_pw = 1'b0,  // pointwise, columns summed
    layer_dw = 1'b1   // depthwise, column 0 only
  } layer_mode_e;

  typedef struct packed {
    layer_mode_e mode;
    logic [5:0]  row_en;  // active rows, 1 to 32
  } layer_cfg_t;

  // --------------------------------------------------
  // GLB write request
  // --------------------------------------------------
  typedef struct packed {
    logic              we;
    logic [`GLB_AW-1:0] addr;
    logic [`GLB_W-1:0]  data;
  } glb_wr_t;

  // drain word index, two words per row
  typedef logic [5:0] idx_t;

endpackage

/* hdl/opsum_reducer.sv */
`include "opsum_params.svh"

module opsum_reducer (
  input  logic                                  clk,
  input  logic                                  reset,
  input  opsum_pkg::layer_mode_e                mode,
  input  logic [`ROW_NUM*`PE_COLS*`OPSUM_W-1:0] pe_psum,
  input  logic                                  psum_valid,
  output logic [`ROW_NUM*`OPSUM_W-1:0]          opsum_row,
  output logic                                  store_opsum
);

  logic [`ROW_NUM*`OPSUM_W-1:0] next_row;  // reduced, before the register

  // --------------------------------------------------
  // per-row column reduction
  // --------------------------------------------------
  for (genvar r = 0; r < `ROW_NUM; r++) begin : g_row
    logic [`OPSUM_W-1:0] col [`PE_COLS];
    logic [`OPSUM_W-1:0] col_sum;

    always_comb begin
      for (int c = 0; c < `PE_COLS; c++) begin
        col[c] = pe_psum[(r*`PE_COLS + c)*`OPSUM_W +: `OPSUM_W];
      end
    end

    // two's complement add, wraps at 16 bits
    always_comb begin
      col_sum = col[0];
      for (int c = 1; c < `PE_COLS; c++) begin
        col_sum = col_sum + col[c];
      end
    end

    assign next_row[r*`OPSUM_W +: `OPSUM_W] =
      (mode == opsum_pkg::layer_dw) ? col[0] : col_sum;
  end

  // --------------------------------------------------
  // output register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      store_opsum <= 1'b0;
    end else begin
      store_opsum <= psum_valid;  // one cycle behind the psums
    end
  end

  always_ff @(posedge clk) begin
    if (psum_valid) begin
      opsum_row <= next_row;
    end
  end

endmodule

/* hdl/opsum_buffer.sv */
`include "opsum_params.svh"

module opsum_buffer (
  input  logic                         clk,
  input  logic                         reset,
  input  opsum_pkg::layer_mode_e       mode,
  input  logic                         store_opsum,
  input  logic [`ROW_NUM*`OPSUM_W-1:0] opsum_row,
  input  opsum_pkg::idx_t              rd_idx,
  output logic [`GLB_W-1:0]            opsum_word
);

  localparam int ROW_BITS = $clog2(`ROW_NUM);

  // four entries per row, entry 0 is the newest in PW mode
  logic [`OPSUM_W-1:0] entry [`ROW_NUM][`OPSUM_DEPTH];

  logic [ROW_BITS-1:0] rd_row;
  logic                rd_low;  // odd index picks entries 0 and 1

  // --------------------------------------------------
  // row stores
  // --------------------------------------------------
  for (genvar r = 0; r < `ROW_NUM; r++) begin : g_row
    logic [`OPSUM_W-1:0] sample;

    assign sample = opsum_row[r*`OPSUM_W +: `OPSUM_W];

    always_ff @(posedge clk) begin
      if (reset) begin
        for (int e = 0; e < `OPSUM_DEPTH; e++) begin
          entry[r][e] <= '0;
        end
      end else if (store_opsum) begin
        if (mode == opsum_pkg::layer_pw) begin
          entry[r][0] <= sample;
          for (int e = 1; e < `OPSUM_DEPTH; e++) begin
            entry[r][e] <= entry[r][e-1];  // shift toward entry 3
          end
        end else begin
          for (int e = 0; e < `OPSUM_DEPTH-1; e++) begin
            entry[r][e] <= '0;
          end
          entry[r][`OPSUM_DEPTH-1] <= sample;
        end
      end
    end
  end

  // --------------------------------------------------
  // read word mux
  // --------------------------------------------------
  assign rd_row = rd_idx[ROW_BITS:1];
  assign rd_low = rd_idx[0];

  always_comb begin
    if (rd_low) begin
      opsum_word = {entry[rd_row][0], entry[rd_row][1]};
    end else begin
      opsum_word = {entry[rd_row][2], entry[rd_row][3]};  // entry 2 on top
    end
  end

endmodule

/* hdl/opsum_drain_ctrl.sv */
module opsum_drain_ctrl (
  input  logic                  clk,
  input  logic                  reset,
  input  opsum_pkg::layer_cfg_t cfg,
  input  logic                  drain_start,
  input  logic                  ready_op,
  output logic                  valid_op,
  output opsum_pkg::idx_t       rd_idx,
  output logic                  drain_done
);

  opsum_pkg::idx_t step;
  opsum_pkg::idx_t last_idx;
  logic            xfer;

  assign xfer = valid_op && ready_op;

  // --------------------------------------------------
  // index range from the layer config
  // --------------------------------------------------
  // row_en of 32 drops to 0 in the 5-bit slice, so 2*row_en-1 still lands on 63
  always_comb begin
    if (cfg.mode == opsum_pkg::layer_dw) begin
      step     = 6'd2;  // even words only
      last_idx = {cfg.row_en[4:0], 1'b0} - 6'd2;
    end else begin
      step     = 6'd1;
      last_idx = {cfg.row_en[4:0], 1'b0} - 6'd1;
    end
  end

  // --------------------------------------------------
  // drain sequencing
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_op   <= 1'b0;
      rd_idx     <= '0;
      drain_done <= 1'b0;
    end else begin
      drain_done <= 1'b0;
      if (!valid_op) begin
        if (drain_start) begin
          valid_op <= 1'b1;
          rd_idx   <= '0;
        end
      end else if (xfer) begin
        if (rd_idx == last_idx) begin
          valid_op   <= 1'b0;
          rd_idx     <= '0;
          drain_done <= 1'b1;  // lines up with the last GLB write
        end else begin
          rd_idx <= rd_idx + step;
        end
      end
    end
  end

endmodule

/* hdl/glb_write_port.sv */
`include "opsum_params.svh"

module glb_write_port (
  input  logic               clk,
  input  logic               reset,
  input  logic [`GLB_AW-1:0] glb_base,
  input  logic               glb_ready,
  input  logic               valid_op,
  input  logic [`GLB_W-1:0]  opsum_word,
  output logic               ready_op,
  output opsum_pkg::glb_wr_t glb_wr
);

  logic [`GLB_AW-1:0] wr_offset;  // writes so far in this drain
  logic               xfer;

  assign ready_op = glb_ready;  // GLB back-pressure straight through
  assign xfer     = valid_op && glb_ready;

  // --------------------------------------------------
  // running address offset
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_offset <= '0;
    end else if (!valid_op) begin
      wr_offset <= '0;
    end else if (xfer) begin
      wr_offset <= wr_offset + 1'b1;
    end
  end

  // --------------------------------------------------
  // write request register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      glb_wr.we <= 1'b0;
    end else begin
      glb_wr.we <= xfer;
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      glb_wr.addr <= glb_base + wr_offset;
      glb_wr.data <= opsum_word;
    end
  end

endmodule

/* hdl/opsum_unit.sv */
`include "opsum_params.svh"

module opsum_unit (
  input  logic                                  clk,
  input  logic                                  reset,
  input  opsum_pkg::layer_cfg_t                 cfg,
  input  logic [`ROW_NUM*`PE_COLS*`OPSUM_W-1:0] pe_psum,
  input  logic                                  psum_valid,
  input  logic                                  drain_start,
  input  logic [`GLB_AW-1:0]                    glb_base,
  input  logic                                  glb_ready,
  output opsum_pkg::glb_wr_t                    glb_wr,
  output logic                                  drain_done
);

  logic [`ROW_NUM*`OPSUM_W-1:0] opsum_row;
  logic                         store_opsum;
  opsum_pkg::idx_t              rd_idx;
  logic                         valid_op;
  logic                         ready_op;
  logic [`GLB_W-1:0]            opsum_word;

  // --------------------------------------------------
  // store path
  // --------------------------------------------------
  opsum_reducer i_opsum_reducer (
    .clk, .reset, .mode(cfg.mode), .pe_psum, .psum_valid, .opsum_row, .store_opsum
  );

  opsum_buffer i_opsum_buffer (
    .clk, .reset, .mode(cfg.mode), .store_opsum, .opsum_row, .rd_idx, .opsum_word
  );

  // --------------------------------------------------
  // drain path
  // --------------------------------------------------
  opsum_drain_ctrl i_opsum_drain_ctrl (
    .clk, .reset, .cfg, .drain_start, .ready_op, .valid_op, .rd_idx, .drain_done
  );

  glb_write_port i_glb_write_port (
    .clk, .reset, .glb_base, .glb_ready, .valid_op, .opsum_word, .ready_op, .glb_wr
  );

endmodule

/* testbench/opsum_unit_assert.sv */
module opsum_unit_assert (
  input logic            clk,
  input logic            reset,
  input logic            valid_op,
  input logic            ready_op,
  input opsum_pkg::idx_t rd_idx,
  input logic            store_opsum,
  input logic            we,
  input logic            drain_done
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;  // failed assertions so far

  // --------------------------------------------------
  // reset state
  // --------------------------------------------------
  reset_clears: assert property (@(posedge clk) reset |=> !valid_op && !we && !drain_done)
    else begin
      $error("valid_op, glb_wr.we or drain_done high after reset");
      fail_count++;
    end

  // --------------------------------------------------
  // drain handshake
  // --------------------------------------------------
  // stalled word holds its index
  stall_holds: assert property (@(posedge clk) disable iff (reset)
    valid_op && !ready_op |=> valid_op && $stable(rd_idx))
    else begin
      $error("valid_op dropped or rd_idx moved while ready_op was low");
      fail_count++;
    end

  no_write_idle: assert property (@(posedge clk) disable iff (reset)
    !(valid_op && ready_op) |=> !we)
    else begin
      $error("glb_wr.we high in the cycle after a non-transfer");
      fail_count++;
    end

  write_follows: assert property (@(posedge clk) disable iff (reset)
    valid_op && ready_op |=> we)
    else begin
      $error("transfer not followed by a GLB write");
      fail_count++;
    end

  done_with_write: assert property (@(posedge clk) disable iff (reset) drain_done |-> we)
    else begin
      $error("drain_done not aligned with the last GLB write");
      fail_count++;
    end

  // stores and drains kept apart
  store_drain_excl: assert property (@(posedge clk) disable iff (reset)
    !(store_opsum && valid_op))
    else begin
      $error("store_opsum high during a drain");
      fail_count++;
    end

endmodule

bind opsum_unit opsum_unit_assert i_opsum_unit_assert (
  .clk(clk), .reset(reset), .valid_op(valid_op), .ready_op(ready_op), .rd_idx(rd_idx),
  .store_opsum(store_opsum), .we(glb_wr.we), .drain_done(drain_done)
);

/* testbench/opsum_unit_tb.sv */
`include "opsum_params.svh"

module opsum_unit_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 8;
  localparam int PSUM_BITS  = `ROW_NUM*`PE_COLS*`OPSUM_W;
  localparam int NUM_TESTS  = 6;
  localparam int DRAINS_PER_TEST [NUM_TESTS] = '{1, 1, 1, 1, 1, 2};

  logic                  clk = 1'b0;
  logic                  reset;
  opsum_pkg::layer_cfg_t cfg;
  logic [PSUM_BITS-1:0]  pe_psum;
  logic                  psum_valid;
  logic                  drain_start;
  logic [`GLB_AW-1:0]    glb_base;
  logic                  glb_ready = 1'b1;
  opsum_pkg::glb_wr_t    glb_wr;
  logic                  drain_done;

  // reference entries and expected writes
  logic [`OPSUM_W-1:0] ref_entry [`ROW_NUM][`OPSUM_DEPTH];
  logic [`GLB_W-1:0]   exp_data [$];
  logic [`GLB_AW-1:0]  exp_addr [$];

  int   drain_words;
  int   wr_count = 0;
  int   check_errors = 0;
  int   flow_errors;
  int   tests_run;
  int   tests_failed;
  logic gaps_on = 1'b0;

  opsum_unit i_opsum_unit (
    .clk, .reset, .cfg, .pe_psum, .psum_valid, .drain_start, .glb_base, .glb_ready,
    .glb_wr, .drain_done
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  // random GLB stalls when enabled
  always @(posedge clk) begin
    if (gaps_on) begin
      glb_ready <= ($urandom % 3) != 0;
    end else begin
      glb_ready <= 1'b1;
    end
  end

  function automatic int total_errors();
    return check_errors + flow_errors + i_opsum_unit.i_opsum_unit_assert.fail_count;
  endfunction

  function automatic int drain_total();
    int n;
    n = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      n += DRAINS_PER_TEST[t];
    end
    return n;
  endfunction

  // --------------------------------------------------
  // write checker
  // --------------------------------------------------
  always @(posedge clk) begin
    logic [`GLB_W-1:0]  want_data;
    logic [`GLB_AW-1:0] want_addr;
    if (!reset && glb_wr.we) begin
      if (exp_data.size() == 0) begin
        $display("unexpected GLB write at address %h", glb_wr.addr);
        check_errors++;
      end else begin
        want_data = exp_data.pop_front();
        want_addr = exp_addr.pop_front();
        assert (glb_wr.data == want_data) else begin
          $display("** Error: glb_wr.data = %h, expected %h", glb_wr.data, want_data);
          check_errors++;
        end
        assert (glb_wr.addr == want_addr) else begin
          $display("** Error: glb_wr.addr = %h, expected %h", glb_wr.addr, want_addr);
          check_errors++;
        end
      end
      wr_count++;
    end
    if (!reset && drain_done) begin
      if (wr_count != drain_words) begin
        $display("drain wrote %0d words instead of %0d", wr_count, drain_words);
        check_errors++;
      end
      wr_count = 0;
    end
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  task automatic store_psums(input opsum_pkg::layer_mode_e mode);
    logic [PSUM_BITS-1:0] vec;
    logic [`OPSUM_W-1:0]  col;
    logic [`OPSUM_W-1:0]  sample;
    for (int i = 0; i < `ROW_NUM*`PE_COLS; i++) begin
      vec[i*`OPSUM_W +: `OPSUM_W] = `OPSUM_W'($urandom);
    end
    for (int r = 0; r < `ROW_NUM; r++) begin
      sample = '0;
      for (int c = 0; c < `PE_COLS; c++) begin
        col = vec[(r*`PE_COLS + c)*`OPSUM_W +: `OPSUM_W];
        if (mode == opsum_pkg::layer_pw || c == 0) begin
          sample = sample + col;  // wraps at 16 bits
        end
      end
      if (mode == opsum_pkg::layer_pw) begin
        for (int e = `OPSUM_DEPTH-1; e > 0; e--) begin
          ref_entry[r][e] = ref_entry[r][e-1];
        end
        ref_entry[r][0] = sample;
      end else begin
        for (int e = 0; e < `OPSUM_DEPTH-1; e++) begin
          ref_entry[r][e] = '0;
        end
        ref_entry[r][`OPSUM_DEPTH-1] = sample;
      end
    end
    @(posedge clk);
    cfg.mode   <= mode;
    pe_psum    <= vec;
    psum_valid <= 1'b1;
    @(posedge clk);
    psum_valid <= 1'b0;
    repeat (2) @(posedge clk);  // stored row readable by now
  endtask

  function automatic void push_expected(input int idx, input logic [`GLB_AW-1:0] addr);
    int row;
    row = idx / 2;
    if (idx % 2 == 0) begin
      exp_data.push_back({ref_entry[row][2], ref_entry[row][3]});
    end else begin
      exp_data.push_back({ref_entry[row][0], ref_entry[row][1]});
    end
    exp_addr.push_back(addr);
  endfunction

  task automatic wait_drain_done(input int limit);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!drain_done && cycles < limit);
    if (!drain_done) begin
      $display("drain_done did not arrive within %0d cycles", limit);
      flow_errors++;
    end
  endtask

  task automatic run_drain(input opsum_pkg::layer_mode_e mode, input logic [5:0] row_en,
                           input logic [`GLB_AW-1:0] base, input logic gaps);
    int words;
    int step;
    int idx;
    words = (mode == opsum_pkg::layer_pw) ? 2 * int'(row_en) : int'(row_en);
    step  = (mode == opsum_pkg::layer_pw) ? 1 : 2;
    idx   = 0;
    for (int k = 0; k < words; k++) begin
      push_expected(idx, base + `GLB_AW'(k));
      idx += step;
    end
    drain_words = words;
    gaps_on     <= gaps;
    @(posedge clk);
    cfg         <= '{mode: mode, row_en: row_en};
    glb_base    <= base;
    drain_start <= 1'b1;
    @(posedge clk);
    drain_start <= 1'b0;
    wait_drain_done(words * 4 + 16);
    gaps_on <= 1'b0;
    repeat (3) @(posedge clk);
    if (exp_data.size() != 0) begin
      $display("%0d expected GLB writes never happened", exp_data.size());
      flow_errors++;
      exp_data.delete();
      exp_addr.delete();
    end
  endtask

  task automatic report_test(input string name, input int start_errs);
    tests_run++;
    if (total_errors() == start_errs) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", tests_run, name,
               total_errors() - start_errs);
    end
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    int start_errs;
    void'($urandom(32'h640354ab));
    flow_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    drain_words  = 0;
    reset        = 1'b1;
    cfg          = '{mode: opsum_pkg::layer_pw, row_en: 6'd32};
    pe_psum      = '0;
    psum_valid   = 1'b0;
    drain_start  = 1'b0;
    glb_base     = '0;
    for (int r = 0; r < `ROW_NUM; r++) begin
      for (int e = 0; e < `OPSUM_DEPTH; e++) begin
        ref_entry[r][e] = '0;
      end
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    start_errs = total_errors();
    run_drain(opsum_pkg::layer_pw, 6'd32, 12'h100, 1'b0);  // all zero entries
    report_test("reset state", start_errs);

    start_errs = total_errors();
    repeat (4) store_psums(opsum_pkg::layer_pw);
    run_drain(opsum_pkg::layer_pw, 6'd32, 12'h200, 1'b0);
    report_test("pw accumulate and history", start_errs);

    start_errs = total_errors();
    store_psums(opsum_pkg::layer_dw);
    run_drain(opsum_pkg::layer_dw, 6'd5, 12'h300, 1'b0);
    report_test("dw mode", start_errs);

    start_errs = total_errors();
    store_psums(opsum_pkg::layer_pw);
    run_drain(opsum_pkg::layer_pw, 6'd7, 12'h400, 1'b0);
    report_test("partial rows", start_errs);

    start_errs = total_errors();
    repeat (2) store_psums(opsum_pkg::layer_pw);
    run_drain(opsum_pkg::layer_pw, 6'd32, 12'h500, 1'b1);
    report_test("back-pressure", start_errs);

    start_errs = total_errors();
    store_psums(opsum_pkg::layer_dw);
    run_drain(opsum_pkg::layer_dw, 6'd32, 12'h600, 1'b0);
    store_psums(opsum_pkg::layer_pw);
    run_drain(opsum_pkg::layer_pw, 6'd3, 12'h700, 1'b0);
    report_test("store and drain exclusion", start_errs);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
             total_errors());
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // watchdog, sized from the drains of all tests
  initial begin
    int limit_ns;
    limit_ns = drain_total() * 64 * 4 * CLK_PERIOD;
    #(limit_ns);
    $display("timeout: run still going after %0d ns", limit_ns);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* opsum_unit.f */
+incdir+include
hdl/opsum_pkg.sv
hdl/opsum_reducer.sv
hdl/opsum_buffer.sv
hdl/opsum_drain_ctrl.sv
hdl/glb_write_port.sv
hdl/opsum_unit.sv
testbench/opsum_unit_assert.sv
testbench/opsum_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the opsum_unit testbench with Verilator.
# Exits non-zero when the build fails, the simulation fails, or the log
# reports a failing test.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
  --top-module opsum_unit_tb -Mdir "$OBJ" -f opsum_unit.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

# keep running after an assertion error so the testbench can report
"./$OBJ/Vopsum_unit_tb" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
  echo "result: fail"
  exit 1
fi

echo "result: pass"
exit 0
